// ==== rtl/colorMapper_defines.svh ====
// Color mapper constants for screen geometry, sprite placement and the APB register map
`ifndef COLOR_MAPPER_DEFINES_SVH
`define COLOR_MAPPER_DEFINES_SVH

// screen coordinates
`define COORD_WIDTH 10

// fixed pipe obstacle
`define PIPE_X 300
`define PIPE_Y 380
`define PIPE_W 50
`define PIPE_H 100

// heart icons, one row
`define HEART_Y    20
`define HEART_SIZE 50
`define HEART0_X   450
`define HEART1_X   500
`define HEART2_X   550

// collision point inside the ball
`define BALL_PROBE_OFFSET 30

// ball register reset values
`define BALL_X_RESET    100
`define BALL_Y_RESET    100
`define BALL_SIZE_RESET 32

// APB register map
`define REG_BALL_X    4'h0
`define REG_BALL_Y    4'h4
`define REG_BALL_SIZE 4'h8
`define REG_STATUS    4'hC

`define APB_ADDR_WIDTH 4
`define APB_DATA_WIDTH 32

`endif

// ==== rtl/colorMapperPkg.sv ====
// Color mapper types, lives FSM states and the fixed color palette
`include "colorMapper_defines.svh"

package colorMapperPkg;

    typedef logic [`COORD_WIDTH-1:0] coord_t;
    typedef logic [2:0] paletteIdx_t;
    typedef logic [7:0] colorByte_t;

    // lives left, 0 to 3
    typedef logic [1:0] lives_t;

    // one bit per heart, bit 0 is the leftmost
    typedef logic [2:0] heartMask_t;

    typedef enum logic [2:0]
    {
        threeLives,
        hitFromThree,
        twoLives,
        hitFromTwo,
        oneLife,
        noLives
    } livesState_t;

    // --------------------------------------------------
    // palette, 24-bit RGB
    // --------------------------------------------------
    localparam paletteIdx_t PAL_BALL       = 3'd0;
    localparam paletteIdx_t PAL_PIPE       = 3'd2;
    localparam paletteIdx_t PAL_HEART      = 3'd3;
    localparam paletteIdx_t PAL_BACKGROUND = 3'd7;

    localparam logic [23:0] PALETTE [8] = '{
        24'h00FF44, 24'hFFDDEE, 24'hCC7711, 24'hDD00FF,
        24'h662255, 24'h662266, 24'h000000, 24'h0000FF
    };

endpackage

// ==== rtl/sceneHitIf.sv ====
// Hit flags passed from the sprite hit stage to the layer priority stage
`timescale 1ns/1ps

interface sceneHitIf;
    import colorMapperPkg::*;

    logic       valid;
    // high when the pixel is blanked
    logic       blank;
    logic       ballHit;
    logic       pipeHit;
    heartMask_t heartHit;

    modport source
    (
        output valid, blank, ballHit, pipeHit, heartHit
    );

    modport sink
    (
        input valid, blank, ballHit, pipeHit, heartHit
    );

endinterface

// ==== rtl/apbSceneRegs.sv ====
// APB slave for the ball position and size registers and the lives status
`timescale 1ns/1ps
`include "colorMapper_defines.svh"

module apbSceneRegs
(
    input  logic                       Clk,
    input  logic                       Reset,
    input  logic                       PSel,
    input  logic                       PEnable,
    input  logic                       PWrite,
    input  logic [`APB_ADDR_WIDTH-1:0] PAddr,
    input  logic [`APB_DATA_WIDTH-1:0] PWData,
    output logic [`APB_DATA_WIDTH-1:0] PRData,
    output logic                       PReady,
    output logic                       PSlvErr,
    input  colorMapperPkg::lives_t     livesLeft,
    output colorMapperPkg::coord_t     ballX,
    output colorMapperPkg::coord_t     ballY,
    output colorMapperPkg::coord_t     ballSize
);
    import colorMapperPkg::*;

    logic [`APB_DATA_WIDTH-1:0] readData;
    logic addrHit;
    logic accessErr;
    logic setupPhase;
    logic writeEn;

    // no wait states
    assign PReady = 1'b1;

    // --------------------------------------------------
    // address decode and read mux
    // --------------------------------------------------
    always_comb
    begin
        readData = '0;
        addrHit  = 1'b1;
        case (PAddr)
            `REG_BALL_X:    readData[`COORD_WIDTH-1:0] = ballX;
            `REG_BALL_Y:    readData[`COORD_WIDTH-1:0] = ballY;
            `REG_BALL_SIZE: readData[`COORD_WIDTH-1:0] = ballSize;
            `REG_STATUS:    readData[$bits(lives_t)-1:0] = livesLeft;
            default:        addrHit = 1'b0;
        endcase
    end

    // status is read only
    assign accessErr  = ~addrHit | (PWrite & (PAddr == `REG_STATUS));
    assign setupPhase = PSel & ~PEnable;
    assign writeEn    = PSel & PEnable & PWrite & ~accessErr;

    // read data and error prepared during setup, valid in access phase
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            PRData  <= '0;
            PSlvErr <= 1'b0;
        end
        else
        begin
            PSlvErr <= setupPhase & accessErr;
            if (setupPhase & ~PWrite)
                PRData <= readData;
        end
    end

    // --------------------------------------------------
    // ball registers
    // --------------------------------------------------
    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            ballX    <= coord_t'(`BALL_X_RESET);
            ballY    <= coord_t'(`BALL_Y_RESET);
            ballSize <= coord_t'(`BALL_SIZE_RESET);
        end
        else if (writeEn)
        begin
            if (PAddr == `REG_BALL_X)
                ballX <= PWData[`COORD_WIDTH-1:0];
            if (PAddr == `REG_BALL_Y)
                ballY <= PWData[`COORD_WIDTH-1:0];
            if (PAddr == `REG_BALL_SIZE)
                ballSize <= PWData[`COORD_WIDTH-1:0];
        end
    end

endmodule

// ==== rtl/livesTracker.sv ====
// Lives FSM, takes a life each time the ball probe enters the pipe
`timescale 1ns/1ps
`include "colorMapper_defines.svh"

module livesTracker
(
    input  logic                       Clk,
    input  logic                       Reset,
    input  colorMapperPkg::coord_t     ballX,
    input  colorMapperPkg::coord_t     ballY,
    output colorMapperPkg::lives_t     livesLeft,
    output colorMapperPkg::heartMask_t heartsIntact
);
    import colorMapperPkg::*;

    livesState_t state;
    livesState_t nextState;
    // one extra bit so the offset cannot wrap
    logic [`COORD_WIDTH:0] probeX;
    logic [`COORD_WIDTH:0] probeY;
    logic collision;
    logic pastPipe;

    assign probeX = {1'b0, ballX} + (`COORD_WIDTH+1)'(`BALL_PROBE_OFFSET);
    assign probeY = {1'b0, ballY} + (`COORD_WIDTH+1)'(`BALL_PROBE_OFFSET);

    // probe strictly inside the pipe
    assign collision = (probeX > `PIPE_X) && (probeX < `PIPE_X + `PIPE_W) &&
                       (probeY > `PIPE_Y) && (probeY < `PIPE_Y + `PIPE_H);
    assign pastPipe  = ballX > `PIPE_X + `PIPE_W;

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            state <= threeLives;
        else
            state <= nextState;
    end

    // hit states wait for the ball to clear the pipe before re-arming
    always_comb
    begin
        nextState = state;
        case (state)
            threeLives:   if (collision) nextState = hitFromThree;
            hitFromThree: if (pastPipe)  nextState = twoLives;
            twoLives:     if (collision) nextState = hitFromTwo;
            hitFromTwo:   if (pastPipe)  nextState = oneLife;
            oneLife:      if (collision) nextState = noLives;
            noLives:      nextState = noLives;
            default:      nextState = threeLives;
        endcase
    end

    // hearts go left to right
    always_comb
    begin
        case (state)
            threeLives:
            begin
                livesLeft    = 2'd3;
                heartsIntact = 3'b111;
            end
            hitFromThree, twoLives:
            begin
                livesLeft    = 2'd2;
                heartsIntact = 3'b110;
            end
            hitFromTwo, oneLife:
            begin
                livesLeft    = 2'd1;
                heartsIntact = 3'b100;
            end
            default:
            begin
                livesLeft    = 2'd0;
                heartsIntact = 3'b000;
            end
        endcase
    end

endmodule

// ==== rtl/spriteHitStage.sv ====
// Pipeline stage 1, registers which sprites cover the current pixel
`timescale 1ns/1ps
`include "colorMapper_defines.svh"

module spriteHitStage
(
    input  logic                       Clk,
    input  logic                       Reset,
    input  colorMapperPkg::coord_t     DrawX,
    input  colorMapperPkg::coord_t     DrawY,
    input  logic                       Blank,
    input  logic                       PixelValid,
    input  colorMapperPkg::coord_t     ballX,
    input  colorMapperPkg::coord_t     ballY,
    input  colorMapperPkg::coord_t     ballSize,
    input  colorMapperPkg::heartMask_t heartsIntact,
    sceneHitIf.source                  hitOut
);
    import colorMapperPkg::*;

    localparam coord_t HEART_LEFT [3] = '{
        coord_t'(`HEART0_X), coord_t'(`HEART1_X), coord_t'(`HEART2_X)
    };

    logic       ballHitD;
    logic       pipeHitD;
    heartMask_t heartHitD;

    // half-open test, left/top inclusive
    function automatic logic inRect(coord_t px, coord_t py, coord_t left, coord_t top,
                                    coord_t w, coord_t h);
        logic [`COORD_WIDTH:0] right;
        logic [`COORD_WIDTH:0] bottom;
        right  = {1'b0, left} + {1'b0, w};
        bottom = {1'b0, top} + {1'b0, h};
        return (px >= left) && ({1'b0, px} < right) &&
               (py >= top) && ({1'b0, py} < bottom);
    endfunction

    always_comb
    begin
        ballHitD = inRect(DrawX, DrawY, ballX, ballY, ballSize, ballSize);
        pipeHitD = inRect(DrawX, DrawY, coord_t'(`PIPE_X), coord_t'(`PIPE_Y),
                          coord_t'(`PIPE_W), coord_t'(`PIPE_H));
        // lost hearts are not drawn
        for (int i = 0; i < $bits(heartMask_t); i++)
            heartHitD[i] = heartsIntact[i] &
                           inRect(DrawX, DrawY, HEART_LEFT[i], coord_t'(`HEART_Y),
                                  coord_t'(`HEART_SIZE), coord_t'(`HEART_SIZE));
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            hitOut.valid <= 1'b0;
        else
            hitOut.valid <= PixelValid;
    end

    // Blank is active low at the input, flipped here
    always_ff @(posedge Clk)
    begin
        if (PixelValid)
        begin
            hitOut.blank    <= ~Blank;
            hitOut.ballHit  <= ballHitD;
            hitOut.pipeHit  <= pipeHitD;
            hitOut.heartHit <= heartHitD;
        end
    end

endmodule

// ==== rtl/layerPriorityStage.sv ====
// Pipeline stage 2, picks the winning layer as a palette index
`timescale 1ns/1ps

module layerPriorityStage
(
    input  logic                        Clk,
    input  logic                        Reset,
    sceneHitIf.sink                     hitIn,
    output logic                        idxValid,
    output logic                        idxBlank,
    output colorMapperPkg::paletteIdx_t colorIdx
);
    import colorMapperPkg::*;

    paletteIdx_t winner;

    // ball over pipe over hearts over background
    always_comb
    begin
        if (hitIn.ballHit)
            winner = PAL_BALL;
        else if (hitIn.pipeHit)
            winner = PAL_PIPE;
        else if (|hitIn.heartHit)
            winner = PAL_HEART;
        else
            winner = PAL_BACKGROUND;
    end

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
            idxValid <= 1'b0;
        else
            idxValid <= hitIn.valid;
    end

    always_ff @(posedge Clk)
    begin
        if (hitIn.valid)
        begin
            idxBlank <= hitIn.blank;
            colorIdx <= winner;
        end
    end

endmodule

// ==== rtl/paletteStage.sv ====
// Pipeline stage 3, looks up the palette and drives RGB with blanking
`timescale 1ns/1ps

module paletteStage
(
    input  logic                        Clk,
    input  logic                        Reset,
    input  logic                        idxValid,
    input  logic                        idxBlank,
    input  colorMapperPkg::paletteIdx_t colorIdx,
    output colorMapperPkg::colorByte_t  Red,
    output colorMapperPkg::colorByte_t  Green,
    output colorMapperPkg::colorByte_t  Blue,
    output logic                        RgbValid
);
    import colorMapperPkg::*;

    logic [23:0] rgb;

    // black while blanked
    assign rgb = idxBlank ? 24'h000000 : PALETTE[colorIdx];

    always_ff @(posedge Clk or posedge Reset)
    begin
        if (Reset)
        begin
            RgbValid <= 1'b0;
            Red      <= '0;
            Green    <= '0;
            Blue     <= '0;
        end
        else
        begin
            RgbValid <= idxValid;
            // hold last color between valid pixels
            if (idxValid)
            begin
                Red   <= rgb[23:16];
                Green <= rgb[15:8];
                Blue  <= rgb[7:0];
            end
        end
    end

endmodule

// ==== rtl/colorMapperTop.sv ====
// Color mapper top, APB registers, lives FSM and the three-stage pixel pipeline
`timescale 1ns/1ps
`include "colorMapper_defines.svh"

module colorMapperTop
(
    input  logic                       Clk,
    input  logic                       Reset,
    // APB slave
    input  logic                       PSel,
    input  logic                       PEnable,
    input  logic                       PWrite,
    input  logic [`APB_ADDR_WIDTH-1:0] PAddr,
    input  logic [`APB_DATA_WIDTH-1:0] PWData,
    output logic [`APB_DATA_WIDTH-1:0] PRData,
    output logic                       PReady,
    output logic                       PSlvErr,
    // pixel stream
    input  colorMapperPkg::coord_t     DrawX,
    input  colorMapperPkg::coord_t     DrawY,
    input  logic                       Blank,
    input  logic                       PixelValid,
    output colorMapperPkg::colorByte_t Red,
    output colorMapperPkg::colorByte_t Green,
    output colorMapperPkg::colorByte_t Blue,
    output logic                       RgbValid
);
    import colorMapperPkg::*;

    coord_t      ballX;
    coord_t      ballY;
    coord_t      ballSize;
    lives_t      livesLeft;
    heartMask_t  heartsIntact;
    logic        idxValid;
    logic        idxBlank;
    paletteIdx_t colorIdx;

    sceneHitIf hitBus ();

    // --------------------------------------------------
    // control side
    // --------------------------------------------------
    apbSceneRegs regs
    (
        .Clk       (Clk),
        .Reset     (Reset),
        .PSel      (PSel),
        .PEnable   (PEnable),
        .PWrite    (PWrite),
        .PAddr     (PAddr),
        .PWData    (PWData),
        .PRData    (PRData),
        .PReady    (PReady),
        .PSlvErr   (PSlvErr),
        .livesLeft (livesLeft),
        .ballX     (ballX),
        .ballY     (ballY),
        .ballSize  (ballSize)
    );

    livesTracker lives
    (
        .Clk          (Clk),
        .Reset        (Reset),
        .ballX        (ballX),
        .ballY        (ballY),
        .livesLeft    (livesLeft),
        .heartsIntact (heartsIntact)
    );

    // --------------------------------------------------
    // pixel pipeline, 3 cycles
    // --------------------------------------------------
    spriteHitStage hitStage
    (
        .Clk          (Clk),
        .Reset        (Reset),
        .DrawX        (DrawX),
        .DrawY        (DrawY),
        .Blank        (Blank),
        .PixelValid   (PixelValid),
        .ballX        (ballX),
        .ballY        (ballY),
        .ballSize     (ballSize),
        .heartsIntact (heartsIntact),
        .hitOut       (hitBus.source)
    );

    layerPriorityStage priorityStage
    (
        .Clk      (Clk),
        .Reset    (Reset),
        .hitIn    (hitBus.sink),
        .idxValid (idxValid),
        .idxBlank (idxBlank),
        .colorIdx (colorIdx)
    );

    paletteStage palStage
    (
        .Clk      (Clk),
        .Reset    (Reset),
        .idxValid (idxValid),
        .idxBlank (idxBlank),
        .colorIdx (colorIdx),
        .Red      (Red),
        .Green    (Green),
        .Blue     (Blue),
        .RgbValid (RgbValid)
    );

endmodule

// ==== verif/tbColorMapper.sv ====
// Directed testbench for the color mapper, APB register tasks and a pixel pipeline model
`timescale 1ns/1ps
`include "colorMapper_defines.svh"

module tbColorMapper;
    import colorMapperPkg::*;

    // tests take about 300 cycles, ten times margin
    localparam int TIMEOUT_CYCLES = 3000;

    localparam logic [23:0] RGB_BALL       = 24'h00FF44;
    localparam logic [23:0] RGB_PIPE       = 24'hCC7711;
    localparam logic [23:0] RGB_HEART      = 24'hDD00FF;
    localparam logic [23:0] RGB_BACKGROUND = 24'h0000FF;
    localparam logic [23:0] RGB_BLACK      = 24'h000000;

    logic                       Clk;
    logic                       Reset;
    logic                       PSel;
    logic                       PEnable;
    logic                       PWrite;
    logic [`APB_ADDR_WIDTH-1:0] PAddr;
    logic [`APB_DATA_WIDTH-1:0] PWData;
    logic [`APB_DATA_WIDTH-1:0] PRData;
    logic                       PReady;
    logic                       PSlvErr;
    coord_t                     DrawX;
    coord_t                     DrawY;
    logic                       Blank;
    logic                       PixelValid;
    colorByte_t                 Red;
    colorByte_t                 Green;
    colorByte_t                 Blue;
    logic                       RgbValid;

    int          cycleCount;
    integer      seed;
    // expected pixels, due cycle and color
    int          dueQ[$];
    logic [23:0] rgbQ[$];
    // scene model
    int          modelBallX;
    int          modelBallY;
    int          modelBallSize;
    int          modelLives;
    logic        modelArmed;

    colorMapperTop DUT
    (
        .Clk(Clk), .Reset(Reset),
        .PSel(PSel), .PEnable(PEnable), .PWrite(PWrite), .PAddr(PAddr), .PWData(PWData),
        .PRData(PRData), .PReady(PReady), .PSlvErr(PSlvErr),
        .DrawX(DrawX), .DrawY(DrawY), .Blank(Blank), .PixelValid(PixelValid),
        .Red(Red), .Green(Green), .Blue(Blue), .RgbValid(RgbValid)
    );

    always #50 Clk = ~Clk;

    always @(posedge Clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
            abortRun("Timeout: the tests did not finish within the cycle limit");
    end

    // --------------------------------------------------
    // failure reporting and typed checks
    // --------------------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkColor(input string name, input colorByte_t act, input colorByte_t exp);
        if (act !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    endtask

    task automatic checkLives(input string name, input lives_t act, input lives_t exp);
        if (act !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s expected %0d, got %0d",
                               $time, name, exp, act));
    endtask

    task automatic checkCoord(input string name, input coord_t act, input coord_t exp);
        if (act !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s expected %0d, got %0d",
                               $time, name, exp, act));
    endtask

    task automatic checkBit(input string name, input logic act, input logic exp);
        if (act !== exp)
            abortRun($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
                               $time, name, exp, act));
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic bit inRect(int px, int py, int left, int top, int w, int h);
        return (px >= left) && (px < left + w) && (py >= top) && (py < top + h);
    endfunction

    function automatic logic [23:0] expectedRgb(int x, int y, logic blank);
        int   heartLeft [3];
        int   lost;
        int   i;
        logic heartHit;
        heartLeft[0] = `HEART0_X;
        heartLeft[1] = `HEART1_X;
        heartLeft[2] = `HEART2_X;
        // hearts are lost from the left
        lost = 3 - modelLives;
        heartHit = 1'b0;
        for (i = lost; i < 3; i++)
            heartHit |= inRect(x, y, heartLeft[i], `HEART_Y, `HEART_SIZE, `HEART_SIZE);
        if (!blank)
            return RGB_BLACK;
        if (inRect(x, y, modelBallX, modelBallY, modelBallSize, modelBallSize))
            return RGB_BALL;
        if (inRect(x, y, `PIPE_X, `PIPE_Y, `PIPE_W, `PIPE_H))
            return RGB_PIPE;
        if (heartHit)
            return RGB_HEART;
        return RGB_BACKGROUND;
    endfunction

    task automatic updateLivesModel();
        int   px;
        int   py;
        logic hit;
        px = modelBallX + `BALL_PROBE_OFFSET;
        py = modelBallY + `BALL_PROBE_OFFSET;
        hit = (px > `PIPE_X) && (px < `PIPE_X + `PIPE_W) &&
              (py > `PIPE_Y) && (py < `PIPE_Y + `PIPE_H);
        if (modelArmed && hit && modelLives > 0)
        begin
            modelLives = modelLives - 1;
            modelArmed = 1'b0;
        end
        else if (!modelArmed && modelBallX > `PIPE_X + `PIPE_W)
            modelArmed = 1'b1;
    endtask

    // output side, every pixel due exactly three cycles after entry
    always @(negedge Clk)
    begin : checkOutputs
        logic [23:0] rgb;
        if (!Reset)
        begin
            if (dueQ.size() > 0 && dueQ[0] == cycleCount)
            begin
                void'(dueQ.pop_front());
                rgb = rgbQ.pop_front();
                checkBit("RgbValid", RgbValid, 1'b1);
                checkColor("Red", Red, rgb[23:16]);
                checkColor("Green", Green, rgb[15:8]);
                checkColor("Blue", Blue, rgb[7:0]);
            end
            else
                checkBit("RgbValid", RgbValid, 1'b0);
        end
    end

    // --------------------------------------------------
    // bus and pixel tasks
    // --------------------------------------------------
    task automatic idle();
        PixelValid = 1'b0;
        @(posedge Clk);
        #1;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
        PSel    = 1'b1;
        PEnable = 1'b0;
        PWrite  = 1'b1;
        PAddr   = addr;
        PWData  = data;
        @(posedge Clk);
        #1;
        PEnable = 1'b1;
        err     = PSlvErr;
        checkBit("PReady", PReady, 1'b1);
        @(posedge Clk);
        #1;
        PSel    = 1'b0;
        PEnable = 1'b0;
        PWrite  = 1'b0;
        if (addr == `REG_BALL_X)
            modelBallX = data[`COORD_WIDTH-1:0];
        if (addr == `REG_BALL_Y)
            modelBallY = data[`COORD_WIDTH-1:0];
        if (addr == `REG_BALL_SIZE)
            modelBallSize = data[`COORD_WIDTH-1:0];
        updateLivesModel();
        // lives FSM settles one cycle after the write
        idle();
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
        PSel    = 1'b1;
        PEnable = 1'b0;
        PWrite  = 1'b0;
        PAddr   = addr;
        @(posedge Clk);
        #1;
        PEnable = 1'b1;
        data    = PRData;
        err     = PSlvErr;
        checkBit("PReady", PReady, 1'b1);
        @(posedge Clk);
        #1;
        PSel    = 1'b0;
        PEnable = 1'b0;
    endtask

    task automatic writeReg(input logic [3:0] addr, input int value);
        logic err;
        apbWrite(addr, value, err);
        checkBit("PSlvErr", err, 1'b0);
    endtask

    task automatic checkRegister(input logic [3:0] addr, input string name, input int exp);
        logic [31:0] rd;
        logic        err;
        apbRead(addr, rd, err);
        checkBit("PSlvErr", err, 1'b0);
        checkCoord(name, coord_t'(rd[`COORD_WIDTH-1:0]), coord_t'(exp));
    endtask

    task automatic expectLives(input int exp);
        logic [31:0] rd;
        logic        err;
        apbRead(`REG_STATUS, rd, err);
        checkBit("PSlvErr", err, 1'b0);
        checkBit("PRData upper bits", |rd[31:2], 1'b0);
        checkLives("livesLeft", lives_t'(rd[1:0]), lives_t'(exp));
    endtask

    task automatic drivePixel(input int x, input int y, input logic blank);
        DrawX      = coord_t'(x);
        DrawY      = coord_t'(y);
        Blank      = blank;
        PixelValid = 1'b1;
        dueQ.push_back(cycleCount + 3);
        rgbQ.push_back(expectedRgb(x, y, blank));
        @(posedge Clk);
        #1;
        PixelValid = 1'b0;
    endtask

    task automatic drainPipe();
        while (dueQ.size() != 0)
            idle();
    endtask

    task automatic checkHeartPixels();
        drivePixel(`HEART0_X + 10, `HEART_Y + 10, 1'b1);
        drivePixel(`HEART1_X + 10, `HEART_Y + 10, 1'b1);
        drivePixel(`HEART2_X + 10, `HEART_Y + 10, 1'b1);
        drainPipe();
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic testResetAndRegs();
        logic [31:0] rd;
        logic        err;
        checkBit("RgbValid", RgbValid, 1'b0);
        checkBit("PSlvErr", PSlvErr, 1'b0);
        checkBit("PRData nonzero", |PRData, 1'b0);
        checkColor("Red", Red, 8'h00);
        checkColor("Green", Green, 8'h00);
        checkColor("Blue", Blue, 8'h00);
        checkRegister(`REG_BALL_X, "ballX", `BALL_X_RESET);
        checkRegister(`REG_BALL_Y, "ballY", `BALL_Y_RESET);
        checkRegister(`REG_BALL_SIZE, "ballSize", `BALL_SIZE_RESET);
        expectLives(3);
        writeReg(`REG_BALL_X, 123);
        writeReg(`REG_BALL_Y, 45);
        writeReg(`REG_BALL_SIZE, 20);
        checkRegister(`REG_BALL_X, "ballX", 123);
        checkRegister(`REG_BALL_Y, "ballY", 45);
        checkRegister(`REG_BALL_SIZE, "ballSize", 20);
        // unmapped address and read-only status
        apbRead(4'h2, rd, err);
        checkBit("PSlvErr", err, 1'b1);
        apbWrite(4'h6, 32'd5, err);
        checkBit("PSlvErr", err, 1'b1);
        apbWrite(`REG_STATUS, 32'd0, err);
        checkBit("PSlvErr", err, 1'b1);
        expectLives(3);
        writeReg(`REG_BALL_X, `BALL_X_RESET);
        writeReg(`REG_BALL_Y, `BALL_Y_RESET);
        writeReg(`REG_BALL_SIZE, `BALL_SIZE_RESET);
    endtask

    task automatic testLayerPriority();
        drivePixel(110, 110, 1'b1);
        drivePixel(320, 450, 1'b1);
        drivePixel(460, 30, 1'b1);
        drivePixel(50, 300, 1'b1);
        drivePixel(110, 110, 1'b0);
        drainPipe();
        // ball over the pipe corner, probe stays outside
        writeReg(`REG_BALL_X, 330);
        writeReg(`REG_BALL_Y, 460);
        drivePixel(335, 465, 1'b1);
        drivePixel(320, 400, 1'b1);
        drainPipe();
    endtask

    task automatic testPipelineFlow();
        int   i;
        int   x;
        int   y;
        logic blank;
        for (i = 0; i < 40; i++)
        begin
            x = 250 + $unsigned($random(seed)) % 400;
            y = $unsigned($random(seed)) % 500;
            blank = ($unsigned($random(seed)) % 8) != 0;
            drivePixel(x, y, blank);
            if ($unsigned($random(seed)) % 4 == 0)
                idle();
        end
        drainPipe();
    endtask

    task automatic testLives();
        int k;
        writeReg(`REG_BALL_X, 100);
        writeReg(`REG_BALL_Y, 100);
        // passes over the pipe without entering
        writeReg(`REG_BALL_X, 290);
        writeReg(`REG_BALL_X, 360);
        expectLives(3);
        writeReg(`REG_BALL_Y, 380);
        for (k = 1; k <= 3; k++)
        begin
            writeReg(`REG_BALL_X, 290);
            expectLives(3 - k);
            checkHeartPixels();
            writeReg(`REG_BALL_X, 360);
            expectLives(3 - k);
        end
        writeReg(`REG_BALL_X, 290);
        expectLives(0);
        checkHeartPixels();
    endtask

    initial
    begin
        Clk           = 1'b0;
        Reset         = 1'b1;
        PSel          = 1'b0;
        PEnable       = 1'b0;
        PWrite        = 1'b0;
        PAddr         = '0;
        PWData        = '0;
        DrawX         = '0;
        DrawY         = '0;
        Blank         = 1'b1;
        PixelValid    = 1'b0;
        cycleCount    = 0;
        seed          = 32'hee65_9020;
        modelBallX    = `BALL_X_RESET;
        modelBallY    = `BALL_Y_RESET;
        modelBallSize = `BALL_SIZE_RESET;
        modelLives    = 3;
        modelArmed    = 1'b1;
        repeat (16) @(posedge Clk);
        #1;
        Reset = 1'b0;
        testResetAndRegs();
        testLayerPriority();
        testPipelineFlow();
        testLives();
        drainPipe();
        idle();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== colorMapper.f ====
+incdir+rtl
rtl/colorMapperPkg.sv
rtl/sceneHitIf.sv
rtl/apbSceneRegs.sv
rtl/livesTracker.sv
rtl/spriteHitStage.sv
rtl/layerPriorityStage.sv
rtl/paletteStage.sv
rtl/colorMapperTop.sv
verif/tbColorMapper.sv

// ==== Bender.yml ====
package:
  name: colorMapper

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/colorMapperPkg.sv
      - rtl/sceneHitIf.sv
      - rtl/apbSceneRegs.sv
      - rtl/livesTracker.sv
      - rtl/spriteHitStage.sv
      - rtl/layerPriorityStage.sv
      - rtl/paletteStage.sv
      - rtl/colorMapperTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tbColorMapper.sv
